//--- src/la_defs.svh
`ifndef LA_DEFS_SVH
`define LA_DEFS_SVH

// datapath widths
`define LA_XLEN          32
`define LA_NREG          32
`define LA_RADDR_W       5
`define LA_ALU_OP_W      12

// major opcodes, inst[31:26]
`define LA_OP_LU12I      6'h05
`define LA_OP_PCADDU12I  6'h07
`define LA_OP_MEM        6'h0a
`define LA_OP_JIRL       6'h13
`define LA_OP_B          6'h14
`define LA_OP_BL         6'h15
`define LA_OP_BEQ        6'h16
`define LA_OP_BNE        6'h17
`define LA_OP_BLT        6'h18
`define LA_OP_BGE        6'h19
`define LA_OP_BLTU       6'h1a
`define LA_OP_BGEU       6'h1b

`define LA_RA_REG        5'd1  // link register for bl

`endif

//--- src/id_pkg.sv
package id_pkg;

    `include "la_defs.svh"

    typedef logic [`LA_XLEN-1:0]     word_t;
    typedef logic [`LA_RADDR_W-1:0]  reg_addr_t;
    typedef logic [31:0]             inst_t;
    typedef logic [`LA_ALU_OP_W-1:0] alu_op_t;

    // bit positions inside alu_op_t
    typedef enum int unsigned {
        ALU_ADD  = 0,
        ALU_SUB  = 1,
        ALU_SLT  = 2,
        ALU_SLTU = 3,
        ALU_AND  = 4,
        ALU_NOR  = 5,
        ALU_OR   = 6,
        ALU_XOR  = 7,
        ALU_SLL  = 8,
        ALU_SRL  = 9,
        ALU_SRA  = 10,
        ALU_LUI  = 11
    } alu_idx_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_kind_e;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      res_from_mem;
        logic      mem_we;
        logic      gr_we;
        reg_addr_t dest;
        reg_addr_t rf_raddr1;
        reg_addr_t rf_raddr2;
        logic      need_addr1;
        logic      need_addr2;
        br_kind_e  br_kind;
        word_t     imm;
        word_t     br_offs;    // already shifted left by 2
    } id_ctrl_t;

    typedef struct packed {
        word_t pc;
        inst_t inst;
    } if_id_bus_t;

    typedef struct packed {
        logic  br_taken;
        word_t br_target;
    } id_if_bus_t;

    // bypass source from EX or MEM
    typedef struct packed {
        logic      valid;
        logic      is_load;
        reg_addr_t dest;
        word_t     wdata;
    } fwd_bus_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_bus_t;

    typedef struct packed {
        logic      gr_we;
        logic      mem_we;
        logic      res_from_mem;
        alu_op_t   alu_op;
        word_t     alu_src1;
        word_t     alu_src2;
        reg_addr_t dest;
        word_t     rkd_value;  // store data
        word_t     pc;
        inst_t     inst;
    } id_ex_bus_t;

endpackage

//--- src/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder
    import id_pkg::*;
(
    input  inst_t    inst,
    output id_ctrl_t ctrl
);
    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        is_3r;
    logic        is_2ri5;
    logic        is_2ri12;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_nor, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic inst_b, inst_bl, inst_jirl;

    logic need_ui5, need_si12, need_ui12, need_si20, need_si26, src2_is_4;
    logic cond_br;
    logic src_reg_is_rd;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    assign is_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_2ri5  = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);
    assign is_2ri12 = (op_31_26 == 6'h00);

    assign inst_add_w  = is_3r && (op_19_15 == 5'h00);
    assign inst_sub_w  = is_3r && (op_19_15 == 5'h02);
    assign inst_slt    = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu   = is_3r && (op_19_15 == 5'h05);
    assign inst_nor    = is_3r && (op_19_15 == 5'h08);
    assign inst_and    = is_3r && (op_19_15 == 5'h09);
    assign inst_or     = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor    = is_3r && (op_19_15 == 5'h0b);
    assign inst_sll_w  = is_3r && (op_19_15 == 5'h0e);
    assign inst_srl_w  = is_3r && (op_19_15 == 5'h0f);
    assign inst_sra_w  = is_3r && (op_19_15 == 5'h10);
    assign inst_slli_w = is_2ri5 && (op_19_15 == 5'h01);
    assign inst_srli_w = is_2ri5 && (op_19_15 == 5'h09);
    assign inst_srai_w = is_2ri5 && (op_19_15 == 5'h11);
    assign inst_slti   = is_2ri12 && (op_25_22 == 4'h8);
    assign inst_sltui  = is_2ri12 && (op_25_22 == 4'h9);
    assign inst_addi_w = is_2ri12 && (op_25_22 == 4'ha);
    assign inst_andi   = is_2ri12 && (op_25_22 == 4'hd);
    assign inst_ori    = is_2ri12 && (op_25_22 == 4'he);
    assign inst_xori   = is_2ri12 && (op_25_22 == 4'hf);
    assign inst_ld_w   = (op_31_26 == `LA_OP_MEM) && (op_25_22 == 4'h2);
    assign inst_st_w   = (op_31_26 == `LA_OP_MEM) && (op_25_22 == 4'h6);
    assign inst_lu12i_w   = (op_31_26 == `LA_OP_LU12I) && !inst[25];
    assign inst_pcaddu12i = (op_31_26 == `LA_OP_PCADDU12I) && !inst[25];
    assign inst_jirl = (op_31_26 == `LA_OP_JIRL);
    assign inst_b    = (op_31_26 == `LA_OP_B);
    assign inst_bl   = (op_31_26 == `LA_OP_BL);
    assign inst_beq  = (op_31_26 == `LA_OP_BEQ);
    assign inst_bne  = (op_31_26 == `LA_OP_BNE);
    assign inst_blt  = (op_31_26 == `LA_OP_BLT);
    assign inst_bge  = (op_31_26 == `LA_OP_BGE);
    assign inst_bltu = (op_31_26 == `LA_OP_BLTU);
    assign inst_bgeu = (op_31_26 == `LA_OP_BGEU);

    assign cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_bl | inst_jirl;     // link value pc+4
    assign src_reg_is_rd = cond_br | inst_st_w;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                              | inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.alu_op[ALU_SUB]  = inst_sub_w;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
        ctrl.alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
        ctrl.alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
        ctrl.alu_op[ALU_LUI]  = inst_lu12i_w;

        ctrl.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.src2_is_imm  = need_ui5 | need_si12 | need_ui12 | need_si20 | src2_is_4;
        ctrl.res_from_mem = inst_ld_w;
        ctrl.mem_we       = inst_st_w;
        ctrl.gr_we        = is_3r
                          & (inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_and
                          | inst_or | inst_nor | inst_xor | inst_sll_w | inst_srl_w
                          | inst_sra_w)
                          | need_ui5 | need_si12 & ~inst_st_w | need_ui12 | need_si20
                          | src2_is_4;
        ctrl.dest       = inst_bl ? `LA_RA_REG : rd;
        ctrl.rf_raddr1  = rj;
        ctrl.rf_raddr2  = src_reg_is_rd ? rd : rk;
        ctrl.need_addr1 = is_3r & ~ctrl.src2_is_imm & (|ctrl.alu_op)
                        | need_ui5 | need_si12 | need_ui12 | cond_br | inst_jirl;
        ctrl.need_addr2 = (|ctrl.alu_op) & is_3r | inst_st_w | cond_br;

        if (inst_beq)       ctrl.br_kind = BR_BEQ;
        else if (inst_bne)  ctrl.br_kind = BR_BNE;
        else if (inst_blt)  ctrl.br_kind = BR_BLT;
        else if (inst_bge)  ctrl.br_kind = BR_BGE;
        else if (inst_bltu) ctrl.br_kind = BR_BLTU;
        else if (inst_bgeu) ctrl.br_kind = BR_BGEU;
        else if (inst_b)    ctrl.br_kind = BR_B;
        else if (inst_bl)   ctrl.br_kind = BR_BL;
        else if (inst_jirl) ctrl.br_kind = BR_JIRL;
        else                ctrl.br_kind = BR_NONE;

        if (src2_is_4)      ctrl.imm = 32'd4;
        else if (need_si20) ctrl.imm = {i20, 12'b0};
        else if (need_ui5)  ctrl.imm = {27'b0, rk};
        else if (need_si12) ctrl.imm = {{20{i12[11]}}, i12};
        else if (need_ui12) ctrl.imm = {20'b0, i12};
        else                ctrl.imm = '0;

        ctrl.br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b00}
                                 : {{14{i16[15]}}, i16, 2'b00};  // si16 also for jirl
    end

endmodule

//--- src/regfile.sv
`timescale 1ns/100ps

module regfile
    import id_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);
    `include "la_defs.svh"

    word_t rf [`LA_NREG];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            rf[waddr] <= wdata;   // r0 stays unwritten
        end
    end

    // r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

//--- src/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass
    import id_pkg::*;
(
    input  id_ctrl_t ctrl,
    input  word_t    rdata1,
    input  word_t    rdata2,
    input  fwd_bus_t ex_fwd,
    input  fwd_bus_t mem_fwd,
    input  wb_bus_t  wb_bus,
    output word_t    rj_value,
    output word_t    rkd_value,
    output logic     load_use_stall
);
    logic ex_hit1;
    logic ex_hit2;
    logic mem_hit1;
    logic mem_hit2;
    logic wb_hit1;
    logic wb_hit2;

    function automatic logic src_hit(
        input logic      vld,
        input reg_addr_t dest,
        input reg_addr_t addr,
        input logic      need
    );
        return vld && need && (dest == addr) && (addr != '0);
    endfunction

    assign ex_hit1  = src_hit(ex_fwd.valid,  ex_fwd.dest,  ctrl.rf_raddr1, ctrl.need_addr1);
    assign ex_hit2  = src_hit(ex_fwd.valid,  ex_fwd.dest,  ctrl.rf_raddr2, ctrl.need_addr2);
    assign mem_hit1 = src_hit(mem_fwd.valid, mem_fwd.dest, ctrl.rf_raddr1, ctrl.need_addr1);
    assign mem_hit2 = src_hit(mem_fwd.valid, mem_fwd.dest, ctrl.rf_raddr2, ctrl.need_addr2);
    assign wb_hit1  = src_hit(wb_bus.we,     wb_bus.waddr, ctrl.rf_raddr1, ctrl.need_addr1);
    assign wb_hit2  = src_hit(wb_bus.we,     wb_bus.waddr, ctrl.rf_raddr2, ctrl.need_addr2);

    // youngest producer wins
    assign rj_value  = ex_hit1  ? ex_fwd.wdata  :
                       mem_hit1 ? mem_fwd.wdata :
                       wb_hit1  ? wb_bus.wdata  : rdata1;
    assign rkd_value = ex_hit2  ? ex_fwd.wdata  :
                       mem_hit2 ? mem_fwd.wdata :
                       wb_hit2  ? wb_bus.wdata  : rdata2;

    // load data not ready until MEM
    assign load_use_stall = ex_fwd.is_load && (ex_hit1 || ex_hit2);

endmodule

//--- src/branch_unit.sv
`timescale 1ns/100ps

module branch_unit
    import id_pkg::*;
(
    input  br_kind_e br_kind,
    input  word_t    pc,
    input  word_t    br_offs,
    input  word_t    rj_value,
    input  word_t    rkd_value,
    output logic     br_taken,
    output word_t    br_target
);
    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rj_value == rkd_value);
    assign lt_s = ($signed(rj_value) < $signed(rkd_value));
    assign lt_u = (rj_value < rkd_value);

    always_comb begin
        case (br_kind)
            BR_BEQ:  br_taken = eq;
            BR_BNE:  br_taken = !eq;
            BR_BLT:  br_taken = lt_s;
            BR_BGE:  br_taken = !lt_s;
            BR_BLTU: br_taken = lt_u;
            BR_BGEU: br_taken = !lt_u;
            BR_B,
            BR_BL,
            BR_JIRL: br_taken = 1'b1;  // unconditional
            default: br_taken = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign br_target = (br_kind == BR_JIRL) ? (rj_value + br_offs) : (pc + br_offs);

endmodule

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
    import id_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    input  logic       if_id_valid,
    input  if_id_bus_t if_id_bus,
    output logic       id_allowin,
    output id_if_bus_t id_if_bus,

    input  logic       ex_allowin,
    output logic       id_ex_valid,
    output id_ex_bus_t id_ex_bus,

    input  fwd_bus_t   ex_fwd,
    input  fwd_bus_t   mem_fwd,
    input  wb_bus_t    wb_bus
);
    logic       id_valid;
    logic       ready_go;
    logic       flush;
    if_id_bus_t id_buf;
    id_ctrl_t   ctrl;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    word_t      rj_value;
    word_t      rkd_value;
    logic       load_use_stall;
    logic       br_taken;
    word_t      br_target;

    assign ready_go    = ~load_use_stall;
    assign id_ex_valid = id_valid & ready_go;
    assign id_allowin  = ~id_valid | (id_ex_valid & ex_allowin);
    assign flush       = id_valid & ready_go & br_taken;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;   // drop wrong-path fetch too
        end else if (id_allowin) begin
            id_valid <= if_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_valid && id_allowin) begin
            id_buf <= if_id_bus;
        end
    end

    inst_decoder u_decoder (
        .inst (id_buf.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (ctrl.rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (wb_bus.we),
        .waddr  (wb_bus.waddr),
        .wdata  (wb_bus.wdata)
    );

    operand_bypass u_bypass (
        .ctrl           (ctrl),
        .rdata1         (rf_rdata1),
        .rdata2         (rf_rdata2),
        .ex_fwd         (ex_fwd),
        .mem_fwd        (mem_fwd),
        .wb_bus         (wb_bus),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .load_use_stall (load_use_stall)
    );

    branch_unit u_branch (
        .br_kind   (ctrl.br_kind),
        .pc        (id_buf.pc),
        .br_offs   (ctrl.br_offs),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    always_comb begin
        id_if_bus.br_taken  = flush;
        id_if_bus.br_target = br_target;

        id_ex_bus.gr_we        = ctrl.gr_we;
        id_ex_bus.mem_we       = ctrl.mem_we;
        id_ex_bus.res_from_mem = ctrl.res_from_mem;
        id_ex_bus.alu_op       = ctrl.alu_op;
        id_ex_bus.alu_src1     = ctrl.src1_is_pc ? id_buf.pc : rj_value;
        id_ex_bus.alu_src2     = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        id_ex_bus.dest         = ctrl.dest;
        id_ex_bus.rkd_value    = rkd_value;
        id_ex_bus.pc           = id_buf.pc;
        id_ex_bus.inst         = id_buf.inst;
    end

endmodule

//--- tests/decode_stage_assert.sv
`timescale 1ns/100ps

module decode_stage_assert
    import id_pkg::*;
(
    input logic       clk,
    input logic       resetn,
    input logic       id_valid,
    input logic       id_ex_valid,
    input logic       ex_allowin,
    input id_ex_bus_t id_ex_bus,
    input id_if_bus_t id_if_bus
);

    // stage empty once reset was seen
    reset_clears: assert property (@(posedge clk)
        !resetn |=> !id_ex_valid && !id_if_bus.br_taken)
        else $error("output valid in the cycle after reset");

    hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        id_ex_valid && !ex_allowin |=> $stable(id_ex_bus))
        else $error("id_ex_bus changed under back-pressure");

    flush_clears: assert property (@(posedge clk) disable iff (!resetn)
        id_if_bus.br_taken |=> !id_valid)
        else $error("id_valid still set after a taken branch");

endmodule

bind decode_stage decode_stage_assert u_assert (
    .clk         (clk),
    .resetn      (resetn),
    .id_valid    (id_valid),
    .id_ex_valid (id_ex_valid),
    .ex_allowin  (ex_allowin),
    .id_ex_bus   (id_ex_bus),
    .id_if_bus   (id_if_bus)
);

//--- tests/decode_stage_tb.sv
`timescale 1ns/100ps

`include "la_defs.svh"

module decode_stage_tb
    import id_pkg::*;
();
    logic       clk = 1'b0;
    logic       resetn;
    logic       if_id_valid;
    if_id_bus_t if_id_bus;
    logic       id_allowin;
    id_if_bus_t id_if_bus;
    logic       ex_allowin;
    logic       id_ex_valid;
    id_ex_bus_t id_ex_bus;
    fwd_bus_t   ex_fwd;
    fwd_bus_t   mem_fwd;
    wb_bus_t    wb_bus;

    word_t      shadow [32];   // architectural register model
    if_id_bus_t held;          // instruction the stage should hold
    id_ex_bus_t exp_eb;
    id_if_bus_t exp_ib;
    id_ex_bus_t snap;
    logic       prev_flush;
    logic       prev_acc;
    int         checks;
    int         errors;
    int         chk_mark;
    int         err_mark;
    int         cycles;
    word_t      rnd;

    logic [4:0] r3_fn [11] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                               5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    logic [4:0] ri5_fn [3] = '{5'h01, 5'h09, 5'h11};
    logic [3:0] ri12_op [6] = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
    logic [5:0] br_op [9] = '{`LA_OP_BEQ, `LA_OP_BNE, `LA_OP_BLT, `LA_OP_BGE,
                              `LA_OP_BLTU, `LA_OP_BGEU, `LA_OP_B, `LA_OP_BL,
                              `LA_OP_JIRL};

    decode_stage decode_stage_i (
        .clk         (clk),
        .resetn      (resetn),
        .if_id_valid (if_id_valid),
        .if_id_bus   (if_id_bus),
        .id_allowin  (id_allowin),
        .id_if_bus   (id_if_bus),
        .ex_allowin  (ex_allowin),
        .id_ex_valid (id_ex_valid),
        .id_ex_bus   (id_ex_bus),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb_bus      (wb_bus)
    );

    always #4 clk = ~clk;

    // operand value after bypass, youngest stage first
    function automatic word_t fwd_val(input reg_addr_t a, input logic need);
        if (need && a != '0 && ex_fwd.valid && ex_fwd.dest == a) return ex_fwd.wdata;
        if (need && a != '0 && mem_fwd.valid && mem_fwd.dest == a) return mem_fwd.wdata;
        if (need && a != '0 && wb_bus.we && wb_bus.waddr == a) return wb_bus.wdata;
        return shadow[a];
    endfunction

    function automatic void ref_decode(input if_id_bus_t ib_in, output id_ex_bus_t eb,
                                       output id_if_bus_t fb);
        inst_t     inst;
        reg_addr_t a2;
        logic      need1;
        logic      need2;
        logic      s1pc;
        logic      s2imm;
        word_t     imm;
        word_t     si12;
        word_t     v1;
        word_t     v2;
        word_t     off16;
        word_t     off26;
        br_kind_e  bk;
        inst = ib_in.inst;
        eb = '0;
        fb = '0;
        need1 = 1'b0;
        need2 = 1'b0;
        s1pc = 1'b0;
        s2imm = 1'b0;
        imm = '0;
        a2 = inst[14:10];
        bk = BR_NONE;
        eb.dest = inst[4:0];
        si12 = {{20{inst[21]}}, inst[21:10]};
        off16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        off26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        if (inst[31:22] == 10'h000 && inst[21:20] == 2'h1) begin
            need1 = 1'b1;
            need2 = 1'b1;
            eb.gr_we = 1'b1;
            case (inst[19:15])
                5'h00: eb.alu_op[ALU_ADD] = 1'b1;
                5'h02: eb.alu_op[ALU_SUB] = 1'b1;
                5'h04: eb.alu_op[ALU_SLT] = 1'b1;
                5'h05: eb.alu_op[ALU_SLTU] = 1'b1;
                5'h08: eb.alu_op[ALU_NOR] = 1'b1;
                5'h09: eb.alu_op[ALU_AND] = 1'b1;
                5'h0a: eb.alu_op[ALU_OR] = 1'b1;
                5'h0b: eb.alu_op[ALU_XOR] = 1'b1;
                5'h0e: eb.alu_op[ALU_SLL] = 1'b1;
                5'h0f: eb.alu_op[ALU_SRL] = 1'b1;
                default: eb.alu_op[ALU_SRA] = 1'b1;
            endcase
        end else if (inst[31:22] == 10'h001 && inst[21:20] == 2'h0) begin
            need1 = 1'b1;
            s2imm = 1'b1;
            eb.gr_we = 1'b1;
            imm = {27'b0, inst[14:10]};
            case (inst[19:15])
                5'h01: eb.alu_op[ALU_SLL] = 1'b1;
                5'h09: eb.alu_op[ALU_SRL] = 1'b1;
                default: eb.alu_op[ALU_SRA] = 1'b1;
            endcase
        end else if (inst[31:26] == 6'h00) begin
            need1 = 1'b1;
            s2imm = 1'b1;
            eb.gr_we = 1'b1;
            imm = si12;
            case (inst[25:22])
                4'h8: eb.alu_op[ALU_SLT] = 1'b1;
                4'h9: eb.alu_op[ALU_SLTU] = 1'b1;
                4'ha: eb.alu_op[ALU_ADD] = 1'b1;
                4'hd: eb.alu_op[ALU_AND] = 1'b1;
                4'he: eb.alu_op[ALU_OR] = 1'b1;
                default: eb.alu_op[ALU_XOR] = 1'b1;
            endcase
            if (inst[25:22] >= 4'hd) imm = {20'b0, inst[21:10]};   // logical ops zero extend
        end else if (inst[31:26] == `LA_OP_MEM) begin
            need1 = 1'b1;
            s2imm = 1'b1;
            imm = si12;
            eb.alu_op[ALU_ADD] = 1'b1;
            if (inst[25:22] == 4'h6) begin
                eb.mem_we = 1'b1;
                need2 = 1'b1;
                a2 = inst[4:0];
            end else begin
                eb.res_from_mem = 1'b1;
                eb.gr_we = 1'b1;
            end
        end else if (inst[31:26] == `LA_OP_LU12I || inst[31:26] == `LA_OP_PCADDU12I) begin
            s2imm = 1'b1;
            eb.gr_we = 1'b1;
            imm = {inst[24:5], 12'b0};
            s1pc = (inst[31:26] == `LA_OP_PCADDU12I);
            if (s1pc) eb.alu_op[ALU_ADD] = 1'b1;
            else eb.alu_op[ALU_LUI] = 1'b1;
        end else if (inst[31:26] == `LA_OP_B) begin
            bk = BR_B;
        end else if (inst[31:26] == `LA_OP_BL || inst[31:26] == `LA_OP_JIRL) begin
            s1pc = 1'b1;
            s2imm = 1'b1;
            imm = 32'd4;    // link address pc+4
            eb.gr_we = 1'b1;
            eb.alu_op[ALU_ADD] = 1'b1;
            need1 = (inst[31:26] == `LA_OP_JIRL);
            bk = need1 ? BR_JIRL : BR_BL;
            if (!need1) eb.dest = `LA_RA_REG;
        end else begin
            need1 = 1'b1;
            need2 = 1'b1;
            a2 = inst[4:0];
            case (inst[31:26])
                `LA_OP_BEQ: bk = BR_BEQ;
                `LA_OP_BNE: bk = BR_BNE;
                `LA_OP_BLT: bk = BR_BLT;
                `LA_OP_BGE: bk = BR_BGE;
                `LA_OP_BLTU: bk = BR_BLTU;
                default: bk = BR_BGEU;
            endcase
        end
        v1 = fwd_val(inst[9:5], need1);
        v2 = fwd_val(a2, need2);
        eb.alu_src1 = s1pc ? ib_in.pc : v1;
        eb.alu_src2 = s2imm ? imm : v2;
        eb.rkd_value = v2;
        eb.pc = ib_in.pc;
        eb.inst = inst;
        case (bk)
            BR_BEQ: fb.br_taken = (v1 == v2);
            BR_BNE: fb.br_taken = (v1 != v2);
            BR_BLT: fb.br_taken = ($signed(v1) < $signed(v2));
            BR_BGE: fb.br_taken = ($signed(v1) >= $signed(v2));
            BR_BLTU: fb.br_taken = (v1 < v2);
            BR_BGEU: fb.br_taken = (v1 >= v2);
            BR_NONE: fb.br_taken = 1'b0;
            default: fb.br_taken = 1'b1;
        endcase
        if (bk == BR_JIRL) fb.br_target = v1 + off16;
        else if (bk == BR_B || bk == BR_BL) fb.br_target = ib_in.pc + off26;
        else fb.br_target = ib_in.pc + off16;
    endfunction

    // compares every instruction that leaves, then tracks the model state
    always @(posedge clk) begin
        if (resetn && prev_flush && !prev_acc) begin
            assert (!id_ex_valid) else begin
                errors++;
                $display("CHECK FAILED at %0t: output valid right after a taken branch", $time);
            end
        end
        prev_flush = 1'b0;
        if (resetn && id_ex_valid) begin
            ref_decode(held, exp_eb, exp_ib);
            checks++;
            assert (id_ex_bus == exp_eb) else begin
                errors++;
                $display("CHECK FAILED at %0t: id_ex_bus %h, expected %h",
                         $time, id_ex_bus, exp_eb);
            end
            assert (id_if_bus.br_taken == exp_ib.br_taken
                    && (!exp_ib.br_taken || id_if_bus.br_target == exp_ib.br_target))
            else begin
                errors++;
                $display("CHECK FAILED at %0t: id_if_bus %h, expected %h",
                         $time, id_if_bus, exp_ib);
            end
            prev_flush = exp_ib.br_taken;
        end
        prev_acc = if_id_valid && id_allowin;
        if (prev_acc) held = if_id_bus;
        if (wb_bus.we && wb_bus.waddr != '0) shadow[wb_bus.waddr] = wb_bus.wdata;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 2000) begin
            $display("timeout: the stage did not drain within 2000 cycles");
            $display("tests failed");
            $finish;
        end
    end

    function automatic reg_addr_t rand_reg();
        word_t w;
        w = $urandom;
        return (w[4:0] == 5'd0) ? 5'd1 : w[4:0];
    endfunction

    task automatic issue(input inst_t inst, input word_t pc);
        @(negedge clk);
        if_id_valid = 1'b1;
        if_id_bus = '{pc, inst};
        do @(posedge clk); while (!id_allowin);
        @(negedge clk);
        if_id_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do @(posedge clk); while (!id_allowin);
    endtask

    task automatic run_one(input inst_t inst);
        word_t w;
        w = $urandom;
        issue(inst, {w[31:2], 2'b00});
        wait_idle();
    endtask

    // EX refuses the first cycle the instruction sits in ID
    task automatic run_ex_blocked(input inst_t inst);
        word_t w;
        w = $urandom;
        @(negedge clk);
        ex_allowin = 1'b0;
        issue(inst, {w[31:2], 2'b00});
        @(negedge clk);
        ex_allowin = 1'b1;
        wait_idle();
    endtask

    task automatic test_done(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
        chk_mark = checks;
        err_mark = errors;
    endtask

    initial begin
        int    n;
        word_t w;
        resetn = 1'b0;
        if_id_valid = 1'b0;
        if_id_bus = '0;
        ex_allowin = 1'b1;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_bus = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        void'($urandom(23));
        repeat (8) @(negedge clk);
        resetn = 1'b1;

        // register file, r0 written too
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            rnd = $urandom;
            wb_bus = '{1'b1, r[4:0], rnd | 32'h1};
        end
        @(negedge clk);
        wb_bus = '0;
        run_one({12'h001, 5'h00, 5'd0, 5'd0, 5'd2});
        for (int i = 0; i < 10; i++) begin
            w = $urandom;
            run_one({12'h001, 5'h00, w[14:10], w[9:5], w[4:0]});
        end
        test_done("register file");

        for (int i = 0; i < 40; i++) begin
            w = $urandom;
            n = $urandom_range(0, 7);
            case (n)
                1: run_one({10'h001, 2'h0, ri5_fn[$urandom_range(0, 2)], w[14:0]});
                2: run_one({6'h00, ri12_op[$urandom_range(0, 5)], w[21:0]});
                3: run_one({`LA_OP_LU12I, 1'b0, w[24:0]});
                4: run_one({`LA_OP_PCADDU12I, 1'b0, w[24:0]});
                5: run_one({`LA_OP_MEM, 4'h2, w[21:0]});
                6: run_one({`LA_OP_MEM, 4'h6, w[21:0]});
                default: run_one({12'h001, r3_fn[$urandom_range(0, 10)], w[14:0]});
            endcase
        end
        test_done("decode forms");

        // one source register, three producers
        @(negedge clk);
        ex_fwd = '{1'b1, 1'b0, 5'd5, 32'h1111_0001};
        mem_fwd = '{1'b1, 1'b0, 5'd5, 32'h2222_0002};
        wb_bus = '{1'b1, 5'd5, 32'h3333_0003};
        run_one({12'h001, 5'h00, 5'd6, 5'd5, 5'd9});
        @(negedge clk);
        ex_fwd = '0;
        run_one({12'h001, 5'h00, 5'd5, 5'd5, 5'd9});
        @(negedge clk);
        mem_fwd = '0;
        run_one({12'h001, 5'h00, 5'd6, 5'd5, 5'd9});
        @(negedge clk);
        wb_bus = '0;
        test_done("forwarding priority");

        @(negedge clk);
        rnd = $urandom;
        ex_fwd = '{1'b1, 1'b1, 5'd7, rnd};
        issue({12'h001, 5'h00, 5'd8, 5'd7, 5'd3}, 32'h1c00_0100);
        repeat (3) begin
            @(posedge clk);
            checks++;
            assert (!id_ex_valid && !id_allowin) else begin
                errors++;
                $display("CHECK FAILED at %0t: load-use hazard did not stall", $time);
            end
        end
        @(negedge clk);
        ex_fwd.is_load = 1'b0;
        wait_idle();
        @(negedge clk);
        ex_fwd = '0;
        test_done("load-use stall");

        // EX held off while the branch sits in ID
        for (int k = 0; k < 9; k++) begin
            repeat (3) begin
                w = $urandom;
                if (k >= 6 && k <= 7) begin
                    run_ex_blocked({br_op[k], w[25:0]});
                end else begin
                    run_ex_blocked({br_op[k], w[25:10], w[9:5], w[0] ? w[9:5] : rand_reg()});
                end
            end
        end
        test_done("branches");

        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            ex_allowin = 1'b0;
            w = $urandom;
            issue({12'h001, r3_fn[$urandom_range(0, 10)], w[14:0]}, 32'h1c00_2000);
            snap = id_ex_bus;
            repeat ($urandom_range(1, 6)) begin
                @(posedge clk);
                checks++;
                assert (id_ex_valid && !id_allowin && id_ex_bus == snap) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: output not held under back-pressure", $time);
                end
            end
            @(negedge clk);
            ex_allowin = 1'b1;
            wait_idle();
        end
        test_done("back-pressure");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+src
src/id_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_bypass.sv
src/branch_unit.sv
src/decode_stage.sv
tests/decode_stage_assert.sv
tests/decode_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f \
    --top-module decode_stage_tb -o sim_decode
./obj_dir/sim_decode | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
